//--- bj_macros.svh
`ifndef BJ_MACROS_SVH
`define BJ_MACROS_SVH

// --------------------
// widths
// --------------------
`define BJ_CARD_W 4

`define BJ_SCORE_W 6

// balance saturates at 31
`define BJ_COIN_W 5

// --------------------
// table rules
// --------------------
`define BJ_HAND_MAX 4

`define BJ_START_COIN 30

// dealer stops drawing here
`define BJ_DEALER_STAND 17

// any nonzero value works
`define BJ_LFSR_SEED 8'hA5

`endif

//--- bj_pkg.sv
`default_nettype none

`include "bj_macros.svh"

package bj_pkg;

    // table phases in play order
    typedef enum logic [2:0] {
        PH_BET,
        PH_DEAL,
        PH_PLAYER,
        PH_DEALER,
        PH_RESULT
    } phase_t;

    // one dealt card, ace is 1, faces are 10
    typedef struct packed {
        logic                   valid;
        logic [`BJ_CARD_W-1:0]  value;
    } card_t;

    typedef struct packed {
        logic [`BJ_SCORE_W-1:0] score;
        logic [3:0]             count;
        logic                   busy;        // cards still owed or unscored
        logic                   two_card_21;
    } hand_status_t;

    // levels, all zero outside result phase
    typedef struct packed {
        logic win;
        logic lose;
        logic draw;
    } result_t;

endpackage

`default_nettype wire

//--- card_source.sv
`timescale 1ns/1ps
`default_nettype none

`include "bj_macros.svh"

module card_source
    import bj_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  gnt_any,
    output card_t card
);

    logic [7:0]            lfsr_q;
    logic                  feedback;
    logic [3:0]            rank;     // 1 to 13
    logic [`BJ_CARD_W-1:0] value;
    logic                  valid_q;
    logic [`BJ_CARD_W-1:0] value_q;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    assign rank  = 4'(lfsr_q % 8'd13) + 4'd1;
    assign value = (rank > 4'd10) ? `BJ_CARD_W'd10 : `BJ_CARD_W'(rank); // j q k count 10

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr_q  <= `BJ_LFSR_SEED;
            valid_q <= 1'b0;
        end else begin
            valid_q <= gnt_any;
            if (gnt_any)
                lfsr_q <= {lfsr_q[6:0], feedback};
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_any)
            value_q <= value;
    end

    assign card = '{valid: valid_q, value: value_q};

    a_card_range: assert property (@(posedge clk) disable iff (reset)
        card.valid |-> (card.value >= `BJ_CARD_W'd1 && card.value <= `BJ_CARD_W'd10));

endmodule

`default_nettype wire

//--- card_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module card_arbiter
    import bj_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic req_player,
    input  logic req_dealer,
    output logic gnt_player,
    output logic gnt_dealer,
    output logic gnt_player_q,
    output logic gnt_dealer_q
);

    logic last_player_q;  // player was served last

    // --------------------
    // round robin grant
    // --------------------
    // player wins a tie unless it was served last
    assign gnt_player = req_player && (!req_dealer || !last_player_q);
    assign gnt_dealer = req_dealer && !gnt_player;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_player_q <= 1'b0;   // first tie goes to player
            gnt_player_q  <= 1'b0;
            gnt_dealer_q  <= 1'b0;
        end else begin
            gnt_player_q <= gnt_player;
            gnt_dealer_q <= gnt_dealer;
            if (gnt_player || gnt_dealer)
                last_player_q <= gnt_player;
        end
    end

    // routed card must have exactly one owner
    a_onehot_gnt: assert property (@(posedge clk) disable iff (reset)
        !(gnt_player && gnt_dealer) ##1 !(gnt_player_q && gnt_dealer_q));

endmodule

`default_nettype wire

//--- hand_keeper.sv
`timescale 1ns/1ps
`default_nettype none

`include "bj_macros.svh"

module hand_keeper
    import bj_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         deal_pulse,
    input  logic         draw_pulse,
    input  logic         clear_pulse,
    input  logic         gnt,
    input  card_t        card_in,
    output logic         req,
    output hand_status_t status,
    output card_t        new_card
);

    localparam int IDX_W = $clog2(`BJ_HAND_MAX);

    logic [`BJ_CARD_W-1:0]  cards_q   [`BJ_HAND_MAX];
    logic [`BJ_CARD_W-1:0]  cards_nxt [`BJ_HAND_MAX];
    logic [3:0]             count_q;
    logic [3:0]             count_nxt;
    logic [1:0]             owed_q;
    logic                   arrive;
    logic                   room;
    logic [`BJ_SCORE_W-1:0] sum;
    logic                   has_ace;
    logic [`BJ_SCORE_W-1:0] score_nxt;
    logic [`BJ_SCORE_W-1:0] score_q;
    logic                   two_21_q;
    logic                   last_vld_q;
    logic [`BJ_CARD_W-1:0]  last_val_q;

    assign arrive    = card_in.valid;
    assign count_nxt = count_q + 4'(arrive);
    assign room      = count_nxt < 4'(`BJ_HAND_MAX);  // counts a card in flight
    assign req       = (owed_q != 2'd0) && room;

    // --------------------
    // owed cards
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owed_q <= 2'd0;
        end else if (clear_pulse) begin
            owed_q <= 2'd0;
        end else if (deal_pulse) begin
            owed_q <= 2'd2;
        end else if (draw_pulse) begin
            owed_q <= owed_q + 2'd1;
        end else if (gnt) begin
            owed_q <= owed_q - 2'd1;
        end else if (owed_q != 2'd0 && !room) begin
            owed_q <= 2'd0;   // hand full, forget the rest
        end
    end

    // soft ace scoring over the hand incl. the arriving card
    always_comb begin
        cards_nxt = cards_q;
        if (arrive)
            cards_nxt[count_q[IDX_W-1:0]] = card_in.value;
        sum     = '0;
        has_ace = 1'b0;
        for (int i = 0; i < `BJ_HAND_MAX; i++) begin
            if (4'(i) < count_nxt) begin
                sum = sum + `BJ_SCORE_W'(cards_nxt[i]);
                if (cards_nxt[i] == `BJ_CARD_W'd1)
                    has_ace = 1'b1;
            end
        end
        score_nxt = (has_ace && sum + `BJ_SCORE_W'd10 <= `BJ_SCORE_W'd21) ?
                    sum + `BJ_SCORE_W'd10 : sum;
    end

    always_ff @(posedge clk) begin
        if (arrive)
            cards_q[count_q[IDX_W-1:0]] <= card_in.value;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q    <= 4'd0;
            score_q    <= '0;
            two_21_q   <= 1'b0;
            last_vld_q <= 1'b0;
        end else begin
            last_vld_q <= arrive && !clear_pulse;
            if (clear_pulse) begin
                count_q  <= 4'd0;
                score_q  <= '0;
                two_21_q <= 1'b0;
            end else if (arrive) begin
                count_q  <= count_nxt;
                score_q  <= score_nxt;
                two_21_q <= (count_nxt == 4'd2) && (score_nxt == `BJ_SCORE_W'd21);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arrive)
            last_val_q <= card_in.value;
    end

    assign status.score       = score_q;
    assign status.count       = count_q;
    assign status.busy        = (owed_q != 2'd0) || arrive || deal_pulse || draw_pulse;
    assign status.two_card_21 = two_21_q;

    assign new_card = '{valid: last_vld_q, value: last_val_q};

    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count_q <= 4'(`BJ_HAND_MAX));

endmodule

`default_nettype wire

//--- game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "bj_macros.svh"

module game_fsm
    import bj_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         next,
    input  logic         hit,
    input  logic         stand,
    input  logic         double,
    input  logic         bet_ok,
    input  hand_status_t player,
    input  hand_status_t dealer,
    output phase_t       phase,
    output logic         player_deal,
    output logic         dealer_deal,
    output logic         player_draw,
    output logic         dealer_draw,
    output logic         clear,
    output logic         bet_take,
    output logic         double_take,
    output logic         settle,
    output result_t      result
);

    logic    first_q;    // no player action yet
    logic    doubled_q;  // double card owed or scored
    logic    player_bust;
    logic    dealer_done;
    result_t judged;

    assign player_bust = player.score > `BJ_SCORE_W'd21;
    assign dealer_done = dealer.score >= `BJ_SCORE_W'(`BJ_DEALER_STAND)
                      || dealer.count >= 4'(`BJ_HAND_MAX);

    // --------------------
    // win lose draw
    // --------------------
    always_comb begin
        judged = '0;
        if (player_bust || (dealer.score <= `BJ_SCORE_W'd21 && dealer.score > player.score))
            judged.lose = 1'b1;
        else if (dealer.score > `BJ_SCORE_W'd21 || player.score > dealer.score)
            judged.win = 1'b1;
        else
            judged.draw = 1'b1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase       <= PH_BET;
            first_q     <= 1'b1;
            doubled_q   <= 1'b0;
            player_deal <= 1'b0;
            dealer_deal <= 1'b0;
            player_draw <= 1'b0;
            dealer_draw <= 1'b0;
            clear       <= 1'b0;
            bet_take    <= 1'b0;
            double_take <= 1'b0;
            settle      <= 1'b0;
            result      <= '0;
        end else begin
            // commands are single cycle
            player_deal <= 1'b0;
            dealer_deal <= 1'b0;
            player_draw <= 1'b0;
            dealer_draw <= 1'b0;
            clear       <= 1'b0;
            bet_take    <= 1'b0;
            double_take <= 1'b0;
            settle      <= 1'b0;
            case (phase)
                PH_BET: begin
                    if (next && bet_ok) begin
                        phase       <= PH_DEAL;
                        bet_take    <= 1'b1;
                        player_deal <= 1'b1;
                        dealer_deal <= 1'b1;
                        first_q     <= 1'b1;
                        doubled_q   <= 1'b0;
                    end
                end
                PH_DEAL: begin
                    if (!player.busy && !dealer.busy) begin
                        if (dealer.two_card_21) begin
                            phase  <= PH_RESULT;
                            settle <= 1'b1;
                            result <= judged;
                        end else begin
                            phase <= PH_PLAYER;
                        end
                    end
                end
                PH_PLAYER: begin
                    if (!player.busy) begin
                        if (player_bust) begin
                            phase  <= PH_RESULT;
                            settle <= 1'b1;
                            result <= judged;
                        end else if (doubled_q || player.score == `BJ_SCORE_W'd21 || stand) begin
                            phase <= PH_DEALER;
                        end else if (double && first_q) begin
                            player_draw <= 1'b1;
                            double_take <= 1'b1;
                            doubled_q   <= 1'b1;
                            first_q     <= 1'b0;
                        end else if (hit) begin
                            player_draw <= 1'b1;
                            first_q     <= 1'b0;
                        end
                    end
                end
                PH_DEALER: begin
                    if (!dealer.busy) begin
                        if (dealer_done) begin
                            phase  <= PH_RESULT;
                            settle <= 1'b1;
                            result <= judged;
                        end else begin
                            dealer_draw <= 1'b1;
                        end
                    end
                end
                PH_RESULT: begin
                    if (next) begin
                        phase  <= PH_BET;
                        clear  <= 1'b1;
                        result <= '0;
                    end
                end
                default: phase <= PH_BET;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- coin_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "bj_macros.svh"

module coin_bank
    import bj_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  phase_t                phase,
    input  logic [3:0]            bet,
    input  logic                  bet_take,
    input  logic                  double_take,
    input  logic                  settle,
    input  result_t               result,
    input  logic                  player_21,
    output logic                  bet_ok,
    output logic [`BJ_COIN_W-1:0] coin
);

    localparam logic [7:0] COIN_MAX = 8'((1 << `BJ_COIN_W) - 1);

    logic [`BJ_COIN_W-1:0] stake_q;
    logic [7:0]            payout;
    logic [7:0]            total;
    logic                  double_ok;

    assign bet_ok    = (phase == PH_BET) && (bet != 4'd0) && (`BJ_COIN_W'(bet) <= coin);
    assign double_ok = coin >= stake_q;

    // stake times 4, 2, 1 or 0
    always_comb begin
        payout = 8'd0;
        if (result.win)
            payout = player_21 ? {1'b0, stake_q, 2'b00} : {2'b00, stake_q, 1'b0};
        else if (result.draw)
            payout = 8'(stake_q);
    end

    assign total = 8'(coin) + payout;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coin <= `BJ_COIN_W'(`BJ_START_COIN);
        end else if (bet_take) begin
            coin <= coin - `BJ_COIN_W'(bet);
        end else if (double_take && double_ok) begin
            coin <= coin - stake_q;
        end else if (settle) begin
            coin <= (total > COIN_MAX) ? COIN_MAX[`BJ_COIN_W-1:0] : total[`BJ_COIN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (bet_take)
            stake_q <= `BJ_COIN_W'(bet);
        else if (double_take && double_ok)
            stake_q <= {stake_q[`BJ_COIN_W-2:0], 1'b0};
    end

    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        (bet_take || double_take) |=> coin <= $past(coin));

endmodule

`default_nettype wire

//--- blackjack_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bj_macros.svh"

module blackjack_top
    import bj_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   next,
    input  logic                   hit,
    input  logic                   stand,
    input  logic                   double,
    input  logic [3:0]             bet,
    output logic [`BJ_SCORE_W-1:0] player_score,
    output logic [`BJ_SCORE_W-1:0] dealer_score,
    output card_t                  player_card,
    output card_t                  dealer_card,
    output logic [`BJ_COIN_W-1:0]  coin,
    output phase_t                 phase,
    output result_t                result
);

    hand_status_t player_st, dealer_st;
    card_t        card, card_to_player, card_to_dealer;
    logic         req_player, req_dealer, gnt_player, gnt_dealer;
    logic         gnt_player_q, gnt_dealer_q;
    logic         player_deal, dealer_deal, player_draw, dealer_draw, clear;
    logic         bet_take, double_take, settle, bet_ok;

    // card goes to whoever was granted last cycle
    assign card_to_player = '{valid: card.valid && gnt_player_q, value: card.value};
    assign card_to_dealer = '{valid: card.valid && gnt_dealer_q, value: card.value};
    assign player_score   = player_st.score;
    assign dealer_score   = dealer_st.score;

    card_source u_source (.clk(clk), .reset(reset), .gnt_any(gnt_player || gnt_dealer),
        .card(card));

    card_arbiter u_arbiter (.clk(clk), .reset(reset), .req_player(req_player),
        .req_dealer(req_dealer), .gnt_player(gnt_player), .gnt_dealer(gnt_dealer),
        .gnt_player_q(gnt_player_q), .gnt_dealer_q(gnt_dealer_q));

    hand_keeper u_player (.clk(clk), .reset(reset), .deal_pulse(player_deal),
        .draw_pulse(player_draw), .clear_pulse(clear), .gnt(gnt_player),
        .card_in(card_to_player), .req(req_player), .status(player_st), .new_card(player_card));

    hand_keeper u_dealer (.clk(clk), .reset(reset), .deal_pulse(dealer_deal),
        .draw_pulse(dealer_draw), .clear_pulse(clear), .gnt(gnt_dealer),
        .card_in(card_to_dealer), .req(req_dealer), .status(dealer_st), .new_card(dealer_card));

    game_fsm u_fsm (.clk(clk), .reset(reset), .next(next), .hit(hit), .stand(stand),
        .double(double), .bet_ok(bet_ok), .player(player_st), .dealer(dealer_st),
        .phase(phase), .player_deal(player_deal), .dealer_deal(dealer_deal),
        .player_draw(player_draw), .dealer_draw(dealer_draw), .clear(clear),
        .bet_take(bet_take), .double_take(double_take), .settle(settle), .result(result));

    coin_bank u_bank (.clk(clk), .reset(reset), .phase(phase), .bet(bet), .bet_take(bet_take),
        .double_take(double_take), .settle(settle), .result(result),
        .player_21(player_st.score == `BJ_SCORE_W'd21), .bet_ok(bet_ok), .coin(coin));

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released between rising edges
    end

endmodule

`default_nettype wire

//--- tb_blackjack.sv
`timescale 1ns/1ps
`default_nettype none

`include "bj_macros.svh"

module tb_blackjack
    import bj_pkg::*;
();

    localparam int N_TESTS         = 5;
    localparam int CYCLES_PER_TEST = 2000;

    logic                   clk, reset, next, hit, stand, double;
    logic [3:0]             bet;
    logic [`BJ_SCORE_W-1:0] player_score, dealer_score;
    card_t                  player_card, dealer_card;
    logic [`BJ_COIN_W-1:0]  coin;
    phase_t                 phase;
    result_t                result;

    int          p_cards[$];   // model hands filled from the card strobes
    int          d_cards[$];
    bit          order_q[$];   // 1 for a player card
    int          p_expect;     // player cards the commands should have dealt
    logic [15:0] lfsr;
    int          bal_before;
    int          stake;

    tb_clock u_clock (.clk(clk), .reset(reset));

    blackjack_top dut (.clk(clk), .reset(reset), .next(next), .hit(hit), .stand(stand),
        .double(double), .bet(bet), .player_score(player_score), .dealer_score(dealer_score),
        .player_card(player_card), .dealer_card(dealer_card), .coin(coin), .phase(phase),
        .result(result));

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // soft ace rule over the first n cards
    function automatic int hand_score(input int cards[$], input int n);
        int sum;
        bit ace;
        sum = 0;
        ace = 1'b0;
        for (int i = 0; i < n; i++) begin
            sum += cards[i];
            if (cards[i] == 1)
                ace = 1'b1;
        end
        if (ace && sum + 10 <= 21)
            sum += 10;
        return sum;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bet(output logic [3:0] b);
        b = 4'd0;
        repeat (4) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[2:0], lfsr[0]};
        end
    endtask

    // --------------------
    // card strobe monitor
    // --------------------
    always @(posedge clk) begin
        if (!reset) begin
            if (player_card.valid) begin
                p_cards.push_back(int'(player_card.value));
                order_q.push_back(1'b1);
            end
            if (dealer_card.valid) begin
                d_cards.push_back(int'(dealer_card.value));
                order_q.push_back(1'b0);
            end
            if (p_cards.size() > `BJ_HAND_MAX || d_cards.size() > `BJ_HAND_MAX)
                fail_now("a hand showed more than four cards");
        end
    end

    // all button tasks start and end on a falling edge
    task automatic pulse_next();
        next = 1'b1;
        @(negedge clk);
        next = 1'b0;
    endtask

    task automatic reject_bet(input logic [3:0] b);
        int start_coin;
        start_coin = int'(coin);
        bet        = b;
        pulse_next();
        check("phase", 32'(phase), 32'(PH_BET));
        check("coin", 32'(coin), 32'(start_coin));
    endtask

    task automatic start_round(input logic [3:0] b, input bit first_round);
        int start_coin;
        start_coin = int'(coin);
        p_cards.delete();
        d_cards.delete();
        order_q.delete();
        bet = b;
        pulse_next();
        check("phase", 32'(phase), 32'(PH_DEAL));
        while (phase == PH_DEAL) @(negedge clk);
        check("coin", 32'(coin), 32'(start_coin - int'(b)));
        check("player_count", 32'(p_cards.size()), 32'd2);
        check("dealer_count", 32'(d_cards.size()), 32'd2);
        for (int i = 1; i < 4; i++) begin
            if (order_q[i] == order_q[i - 1])
                fail_now("deal order did not alternate between player and dealer");
        end
        if (first_round)
            check("first_card_owner", 32'(order_q[0]), 32'd1);
        check("player_score", 32'(player_score), 32'(hand_score(p_cards, 2)));
        check("dealer_score", 32'(dealer_score), 32'(hand_score(d_cards, 2)));
        bal_before = start_coin;
        stake      = int'(b);
        p_expect   = 2;
    endtask

    task automatic hit_once();
        int n;
        n        = p_cards.size();
        p_expect = p_expect + 1;
        hit      = 1'b1;
        @(negedge clk);
        hit = 1'b0;
        while (p_cards.size() == n) @(negedge clk);
        check("player_score", 32'(player_score), 32'(hand_score(p_cards, n + 1)));
    endtask

    task automatic stand_now();
        stand = 1'b1;   // level held until the dealer takes over
        while (phase == PH_PLAYER) @(negedge clk);
        stand = 1'b0;
    endtask

    task automatic double_now();
        int n;
        n        = p_cards.size();
        p_expect = p_expect + 1;
        double   = 1'b1;
        @(negedge clk);
        double = 1'b0;
        while (phase == PH_PLAYER) @(negedge clk);
        check("player_count", 32'(p_cards.size()), 32'(n + 1));
        if (bal_before - stake >= stake)
            stake = 2 * stake;
        check("coin", 32'(coin), 32'(bal_before - stake));
    endtask

    task automatic finish_round();
        int      ps;
        int      ds;
        int      dn;
        int      paid;
        int      exp_coin;
        result_t exp_res;
        while (phase != PH_RESULT) @(negedge clk);
        check("player_count", 32'(p_cards.size()), 32'(p_expect));
        dn = d_cards.size();
        ps = hand_score(p_cards, p_cards.size());
        ds = hand_score(d_cards, dn);
        check("player_score", 32'(player_score), 32'(ps));
        check("dealer_score", 32'(dealer_score), 32'(ds));
        if (ps <= 21) begin
            if (ds < `BJ_DEALER_STAND && dn < `BJ_HAND_MAX)
                fail_now("dealer stopped drawing below its stand limit");
            if (dn > 2 && hand_score(d_cards, dn - 1) >= `BJ_DEALER_STAND)
                fail_now("dealer drew a card after reaching its stand limit");
        end
        exp_res = '0;
        if (ps > 21 || (ds <= 21 && ds > ps))
            exp_res.lose = 1'b1;
        else if (ds > 21 || ps > ds)
            exp_res.win = 1'b1;
        else
            exp_res.draw = 1'b1;
        check("result", 32'(result), 32'(exp_res));
        paid = 0;
        if (exp_res.win)
            paid = (ps == 21) ? 4 * stake : 2 * stake;
        else if (exp_res.draw)
            paid = stake;
        exp_coin = bal_before - stake + paid;
        if (exp_coin > 31)
            exp_coin = 31;
        @(negedge clk);   // balance follows settle by one cycle
        check("coin", 32'(coin), 32'(exp_coin));
        pulse_next();
        check("phase", 32'(phase), 32'(PH_BET));
        check("result", 32'(result), 32'd0);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_reset();
        check("coin", 32'(coin), 32'(`BJ_START_COIN));
        check("phase", 32'(phase), 32'(PH_BET));
        check("result", 32'(result), 32'd0);
        reject_bet(4'd0);
    endtask

    task automatic test_deal();
        start_round(4'd5, 1'b1);
        stand_now();
        finish_round();
    endtask

    task automatic test_hit();
        start_round(4'd3, 1'b0);
        while (phase == PH_PLAYER && player_score < `BJ_SCORE_W'd21 && p_cards.size() < 4)
            hit_once();
        if (phase == PH_PLAYER && player_score < `BJ_SCORE_W'd21) begin
            hit = 1'b1;   // full hand so no card may follow
            @(negedge clk);
            hit = 1'b0;
        end
        stand_now();
        finish_round();
    endtask

    task automatic test_stand();
        start_round(4'd4, 1'b0);
        stand_now();
        finish_round();
    endtask

    task automatic test_rounds();
        logic [3:0] b;
        start_round(4'd2, 1'b0);
        if (phase == PH_PLAYER && player_score < `BJ_SCORE_W'd21)
            double_now();
        else
            stand_now();
        finish_round();
        for (int r = 0; r < 12; r++) begin
            random_bet(b);
            if (b == 4'd0) begin
                reject_bet(b);
                continue;
            end
            if (int'(b) > int'(coin)) begin
                reject_bet(b);   // unaffordable so the rounds end here
                break;
            end
            start_round(b, 1'b0);
            if (r % 3 == 0) begin
                while (phase == PH_PLAYER && player_score < `BJ_SCORE_W'd17 && p_cards.size() < 4)
                    hit_once();
            end else if (r % 3 == 1) begin
                if (phase == PH_PLAYER && player_score < `BJ_SCORE_W'd21)
                    double_now();
            end
            stand_now();
            finish_round();
        end
    endtask

    initial begin
        next   = 1'b0;
        hit    = 1'b0;
        stand  = 1'b0;
        double = 1'b0;
        bet    = 4'd0;
        lfsr   = 16'd10;
        @(negedge reset);
        @(negedge clk);
        test_reset();
        test_deal();
        test_hit();
        test_stand();
        test_rounds();
        $display("Simulation finished: PASS");
        $finish;
    end

    // watchdog
    initial begin
        repeat (N_TESTS * CYCLES_PER_TEST) @(posedge clk);
        fail_now("timeout: the tests did not finish in the allowed cycles");
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
bj_pkg.sv
card_source.sv
card_arbiter.sv
hand_keeper.sv
game_fsm.sv
coin_bank.sv
blackjack_top.sv
tb_clock.sv
tb_blackjack.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_blackjack -f src.f
	./obj_dir/Vtb_blackjack | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
